/* verilog/vic_video_pkg.sv */
`default_nettype none

package vic_video_pkg;

    // palette index into the 16 color table
    typedef logic [3:0]  color_t;
    typedef logic [7:0]  pixel_byte_t;
    // bits 11..8 hold the color nibble, bit 11 doubles as multicolor flag
    typedef logic [11:0] char_word_t;
    typedef logic [2:0]  xpos_t;
    typedef logic [6:0]  cycle_t;

    // encoded as {ecm, bmm, mcm}
    typedef enum logic [2:0] {
        MODE_STD_CHAR           = 3'b000,
        MODE_MC_CHAR            = 3'b001,
        MODE_STD_BITMAP         = 3'b010,
        MODE_MC_BITMAP          = 3'b011,
        MODE_EXT_BG             = 3'b100,
        MODE_INV_EXT_MC_CHAR    = 3'b101,
        MODE_INV_EXT_STD_BITMAP = 3'b110,
        MODE_INV_EXT_MC_BITMAP  = 3'b111
    } display_mode_e;

    localparam color_t COLOR_BLACK = 4'h0;

    // xscroll is only picked up inside this window of phi cycles
    localparam cycle_t VISIBLE_FIRST_CYCLE = 7'd15;
    localparam cycle_t VISIBLE_LAST_CYCLE  = 7'd55;

    typedef struct packed {
        color_t b0c;
        color_t b1c;
        color_t b2c;
        color_t b3c;
    } bg_colors_t;

    // execute stage result handed to the result stage
    typedef struct packed {
        color_t pixel_color;
        logic   is_background;
        logic   main_border;
    } stage1_t;

    // ecm combined with bmm or mcm has no defined output
    function automatic logic mode_is_invalid(input display_mode_e mode);
        return mode inside {MODE_INV_EXT_MC_CHAR, MODE_INV_EXT_STD_BITMAP,
                            MODE_INV_EXT_MC_BITMAP};
    endfunction

endpackage

`default_nettype wire

/* verilog/vic_sprite_pkg.sv */
`default_nettype none

package vic_sprite_pkg;

    localparam int NUM_SPRITES = 8;

    // current pixel from each sprite shift register
    typedef logic [1:0] sprite_pix_t;

    // sprite state seen by the result stage
    // index 0 is sprite 0, the highest priority
    typedef struct packed {
        sprite_pix_t [NUM_SPRITES-1:0]           cur_pixel;
        vic_video_pkg::color_t [NUM_SPRITES-1:0] col;
        logic [NUM_SPRITES-1:0]                  pri;
        logic [NUM_SPRITES-1:0]                  mmc;
        vic_video_pkg::color_t                   mc0;
        vic_video_pkg::color_t                   mc1;
    } sprite_bus_t;

endpackage

`default_nettype wire

/* verilog/dot_timing.sv */
`timescale 1ns/1ns
`default_nettype none

module dot_timing (
    input  wire                   clk_dot4x,
    input  wire                   rst,
    output logic                  dot_rising_0_o,
    output logic                  dot_rising_1_o,
    output vic_video_pkg::xpos_t  xpos_mod_8_o,
    output logic                  phase_lp_o,
    output logic                  phase_dav_o,
    output logic                  phase_xscroll_latch_o,
    output vic_video_pkg::cycle_t cycle_num_o
);

    // clock within the phi cycle, 4 clocks per dot and 8 dots per phi
    logic [4:0] phi_clk;
    logic [4:0] phi_clk_next;
    // low bits of the phi clock count are the dot phase
    logic [1:0] dot_phase;

    assign phi_clk_next = phi_clk + 5'd1;
    assign dot_phase    = phi_clk[1:0];

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phi_clk               <= '0;
            xpos_mod_8_o          <= '0;
            cycle_num_o           <= '0;
            dot_rising_0_o        <= 1'b0;
            dot_rising_1_o        <= 1'b0;
            phase_lp_o            <= 1'b0;
            phase_dav_o           <= 1'b0;
            phase_xscroll_latch_o <= 1'b0;
        end else begin
            phi_clk <= phi_clk_next;
            if (dot_phase == 2'd3) begin
                xpos_mod_8_o <= xpos_mod_8_o + 3'd1;
            end
            // 64 phi cycles per line
            if (phi_clk == 5'd31) begin
                cycle_num_o <= (cycle_num_o == 7'd63) ? 7'd0 : cycle_num_o + 7'd1;
            end
            // strobes decode the count being entered
            dot_rising_0_o        <= (phi_clk_next[1:0] == 2'd0);
            dot_rising_1_o        <= (phi_clk_next[1:0] == 2'd1);
            phase_dav_o           <= (phi_clk_next == 5'd4);
            phase_lp_o            <= (phi_clk_next == 5'd28);
            phase_xscroll_latch_o <= (phi_clk_next == 5'd0);
        end
    end

    // both dot edges come from one counter phase each
    assert property (@(posedge clk_dot4x) disable iff (rst)
        !(dot_rising_0_o && dot_rising_1_o));

endmodule

`default_nettype wire

/* verilog/gfx_shifter.sv */
`timescale 1ns/1ns
`default_nettype none

module gfx_shifter (
    input  wire                          clk_dot4x,
    input  wire                          rst,
    input  wire                          dot_rising_0_i,
    input  wire                          dot_rising_1_i,
    input  wire vic_video_pkg::xpos_t    xpos_mod_8_i,
    input  wire                          phase_lp_i,
    input  wire                          phase_dav_i,
    input  wire                          phase_xscroll_latch_i,
    input  wire vic_video_pkg::cycle_t   cycle_num_i,
    input  wire vic_video_pkg::display_mode_e mode_i,
    input  wire vic_video_pkg::xpos_t    xscroll_i,
    input  wire vic_video_pkg::pixel_byte_t pixels_read_i,
    input  wire vic_video_pkg::char_word_t  char_read_i,
    output vic_video_pkg::pixel_byte_t   pixels_shifting_o,
    output vic_video_pkg::char_word_t    char_shifting_o,
    output logic                         is_background_pixel0_o,
    output logic                         stage0_o
);
    import vic_video_pkg::*;

    // {ecm, bmm, mcm}
    logic [2:0]  mode_bits;
    xpos_t       xscroll_q;
    pixel_byte_t pix_d0;
    pixel_byte_t pix_d1;
    pixel_byte_t pix_ready;
    char_word_t  chr_d0;
    char_word_t  chr_d1;
    char_word_t  chr_ready;
    logic        load_pixels;
    logic        is_mc;
    logic        shift_en;

    assign mode_bits   = mode_i;
    assign load_pixels = (xpos_mod_8_i == xscroll_q);
    // pairs of bits per pixel for the shifted cell
    assign is_mc = mode_bits[0] & (mode_bits[1] | mode_bits[2] | char_shifting_o[11]);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            xscroll_q <= '0;
        end else if (phase_xscroll_latch_i && cycle_num_i >= VISIBLE_FIRST_CYCLE &&
                     cycle_num_i <= VISIBLE_LAST_CYCLE) begin
            xscroll_q <= xscroll_i;
        end
    end

    // data must be ready when xpos_mod_8 reaches the scroll value
    always_ff @(posedge clk_dot4x) begin
        if (phase_dav_i) begin
            pix_d0 <= pixels_read_i;
            pix_d1 <= pix_d0;
            chr_d0 <= char_read_i;
            chr_d1 <= chr_d0;
        end
        if (phase_lp_i) begin
            pix_ready <= pix_d1;
            chr_ready <= chr_d1;
        end
    end

    // toggles in multicolor so a bit pair holds for two dots
    // first toggle after a load keeps the leading pair for its second dot
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            shift_en <= 1'b0;
        end else if (dot_rising_0_i) begin
            if (load_pixels) begin
                shift_en <= 1'b1;
            end else if (is_mc) begin
                shift_en <= ~shift_en;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            stage0_o <= 1'b0;
        end else begin
            stage0_o <= dot_rising_1_i;
        end
    end

    // background flag follows the bit that reaches the top next
    always_ff @(posedge clk_dot4x) begin
        if (dot_rising_1_i) begin
            if (load_pixels) begin
                pixels_shifting_o      <= pix_ready;
                char_shifting_o        <= chr_ready;
                is_background_pixel0_o <= ~pix_ready[7];
            end else if (shift_en) begin
                if (is_mc) begin
                    pixels_shifting_o      <= {pixels_shifting_o[5:0], 2'b00};
                    is_background_pixel0_o <= ~pixels_shifting_o[5];
                end else begin
                    pixels_shifting_o      <= {pixels_shifting_o[6:0], 1'b0};
                    is_background_pixel0_o <= ~pixels_shifting_o[6];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/mode_color_resolver.sv */
`timescale 1ns/1ns
`default_nettype none

module mode_color_resolver (
    input  wire                               clk_dot4x,
    input  wire                               rst,
    input  wire                               stage0_i,
    input  wire vic_video_pkg::display_mode_e mode_i,
    input  wire vic_video_pkg::bg_colors_t    bg_i,
    input  wire                               main_border_i,
    input  wire vic_video_pkg::pixel_byte_t   pixels_shifting_i,
    input  wire vic_video_pkg::char_word_t    char_shifting_i,
    input  wire                               is_background_pixel0_i,
    output vic_video_pkg::stage1_t            stage1_o,
    output logic                              stage1_valid_o
);
    import vic_video_pkg::*;

    color_t     color_next;
    color_t     char_color;
    logic [1:0] pix_pair;
    logic       pix_top;

    assign char_color = char_shifting_i[11:8];
    assign pix_pair   = pixels_shifting_i[7:6];
    assign pix_top    = pixels_shifting_i[7];

    always_comb begin
        color_next = COLOR_BLACK;
        case (mode_i)
            MODE_STD_CHAR: begin
                color_next = pix_top ? char_color : bg_i.b0c;
            end
            // invalid multicolor char goes black later
            MODE_MC_CHAR, MODE_INV_EXT_MC_CHAR: begin
                if (char_shifting_i[11]) begin
                    case (pix_pair)
                        2'b00: color_next = bg_i.b0c;
                        2'b01: color_next = bg_i.b1c;
                        2'b10: color_next = bg_i.b2c;
                        default: color_next = {1'b0, char_shifting_i[10:8]};
                    endcase
                end else begin
                    color_next = pix_top ? char_color : bg_i.b0c;
                end
            end
            MODE_STD_BITMAP, MODE_INV_EXT_STD_BITMAP: begin
                color_next = pix_top ? char_shifting_i[7:4] : char_shifting_i[3:0];
            end
            MODE_MC_BITMAP, MODE_INV_EXT_MC_BITMAP: begin
                case (pix_pair)
                    2'b00: color_next = bg_i.b0c;
                    2'b01: color_next = char_shifting_i[7:4];
                    2'b10: color_next = char_shifting_i[3:0];
                    default: color_next = char_color;
                endcase
            end
            MODE_EXT_BG: begin
                // char bits 7..6 pick one of the four backgrounds
                if (pix_top) begin
                    color_next = char_color;
                end else begin
                    case (char_shifting_i[7:6])
                        2'b00: color_next = bg_i.b0c;
                        2'b01: color_next = bg_i.b1c;
                        2'b10: color_next = bg_i.b2c;
                        default: color_next = bg_i.b3c;
                    endcase
                end
            end
            default: color_next = COLOR_BLACK;
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (stage0_i) begin
            stage1_o.pixel_color   <= color_next;
            stage1_o.is_background <= is_background_pixel0_i;
            stage1_o.main_border   <= main_border_i;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            stage1_valid_o <= 1'b0;
        end else begin
            stage1_valid_o <= stage0_i;
        end
    end

    // one resolved pixel per dot, never back to back
    assert property (@(posedge clk_dot4x) disable iff (rst)
        stage1_valid_o |=> !stage1_valid_o);

endmodule

`default_nettype wire

/* verilog/sprite_priority_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module sprite_priority_mux (
    input  wire                               clk_dot4x,
    input  wire                               rst,
    input  wire vic_video_pkg::stage1_t       stage1_i,
    input  wire                               stage1_valid_i,
    input  wire                               dot_rising_1_i,
    input  wire vic_video_pkg::display_mode_e mode_i,
    input  wire vic_video_pkg::color_t        ec_i,
    input  wire vic_sprite_pkg::sprite_bus_t  sprites_i,
    output vic_video_pkg::color_t             pixel_color_o,
    output logic                              is_background_o
);
    import vic_video_pkg::*;
    import vic_sprite_pkg::*;

    color_t base_color;
    color_t sprite_color;
    color_t color2;
    color_t color2a;
    logic   is_bg2;
    logic   is_bg2a;
    logic   border2;
    logic   border2a;

    assign base_color = mode_is_invalid(mode_i) ? COLOR_BLACK : stage1_i.pixel_color;

    // walk from sprite 7 so that sprite 0 ends on top
    always_comb begin
        sprite_color = base_color;
        for (int n = NUM_SPRITES - 1; n >= 0; n--) begin
            if (!sprites_i.pri[n] || stage1_i.is_background) begin
                if (sprites_i.mmc[n]) begin
                    case (sprites_i.cur_pixel[n])
                        2'b01: sprite_color = sprites_i.mc0;
                        2'b10: sprite_color = sprites_i.col[n];
                        2'b11: sprite_color = sprites_i.mc1;
                        default: sprite_color = sprite_color;
                    endcase
                end else if (sprites_i.cur_pixel[n][1]) begin
                    sprite_color = sprites_i.col[n];
                end
            end
            // a behind-foreground sprite also hides lower sprites drawn so far
            if (sprites_i.pri[n] && !stage1_i.is_background && sprites_i.cur_pixel[n][1]) begin
                sprite_color = base_color;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            color2  <= COLOR_BLACK;
            is_bg2  <= 1'b0;
            border2 <= 1'b0;
        end else if (stage1_valid_i) begin
            color2  <= sprite_color;
            is_bg2  <= stage1_i.is_background;
            border2 <= stage1_i.main_border;
        end
    end

    // one extra dot so border edges line up with the pixels
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            color2a  <= COLOR_BLACK;
            is_bg2a  <= 1'b0;
            border2a <= 1'b0;
        end else if (dot_rising_1_i) begin
            color2a  <= color2;
            is_bg2a  <= is_bg2;
            border2a <= border2;
        end
    end

    // border mask
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixel_color_o   <= COLOR_BLACK;
            is_background_o <= 1'b0;
        end else begin
            pixel_color_o   <= border2a ? ec_i : color2a;
            is_background_o <= is_bg2a;
        end
    end

endmodule

`default_nettype wire

/* verilog/pixel_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_sequencer (
    input  wire                               clk_dot4x,
    input  wire                               rst,
    input  wire vic_video_pkg::display_mode_e mode_i,
    input  wire vic_video_pkg::pixel_byte_t   pixels_read_i,
    input  wire vic_video_pkg::char_word_t    char_read_i,
    input  wire vic_video_pkg::xpos_t         xscroll_i,
    input  wire vic_video_pkg::bg_colors_t    bg_i,
    input  wire vic_video_pkg::color_t        ec_i,
    input  wire                               main_border_i,
    input  wire vic_sprite_pkg::sprite_bus_t  sprites_i,
    output vic_video_pkg::color_t             pixel_color_o,
    output logic                              is_background_o
);
    import vic_video_pkg::*;

    logic        dot_rising_0;
    logic        dot_rising_1;
    xpos_t       xpos_mod_8;
    logic        phase_lp;
    logic        phase_dav;
    logic        phase_xscroll_latch;
    cycle_t      cycle_num;
    pixel_byte_t pixels_shifting;
    char_word_t  char_shifting;
    logic        is_background_pixel0;
    logic        stage0;
    stage1_t     stage1;
    logic        stage1_valid;

    dot_timing u_timing (
        .clk_dot4x             (clk_dot4x),
        .rst                   (rst),
        .dot_rising_0_o        (dot_rising_0),
        .dot_rising_1_o        (dot_rising_1),
        .xpos_mod_8_o          (xpos_mod_8),
        .phase_lp_o            (phase_lp),
        .phase_dav_o           (phase_dav),
        .phase_xscroll_latch_o (phase_xscroll_latch),
        .cycle_num_o           (cycle_num)
    );

    gfx_shifter u_decode (
        .clk_dot4x              (clk_dot4x),
        .rst                    (rst),
        .dot_rising_0_i         (dot_rising_0),
        .dot_rising_1_i         (dot_rising_1),
        .xpos_mod_8_i           (xpos_mod_8),
        .phase_lp_i             (phase_lp),
        .phase_dav_i            (phase_dav),
        .phase_xscroll_latch_i  (phase_xscroll_latch),
        .cycle_num_i            (cycle_num),
        .mode_i                 (mode_i),
        .xscroll_i              (xscroll_i),
        .pixels_read_i          (pixels_read_i),
        .char_read_i            (char_read_i),
        .pixels_shifting_o      (pixels_shifting),
        .char_shifting_o        (char_shifting),
        .is_background_pixel0_o (is_background_pixel0),
        .stage0_o               (stage0)
    );

    mode_color_resolver u_execute (
        .clk_dot4x              (clk_dot4x),
        .rst                    (rst),
        .stage0_i               (stage0),
        .mode_i                 (mode_i),
        .bg_i                   (bg_i),
        .main_border_i          (main_border_i),
        .pixels_shifting_i      (pixels_shifting),
        .char_shifting_i        (char_shifting),
        .is_background_pixel0_i (is_background_pixel0),
        .stage1_o               (stage1),
        .stage1_valid_o         (stage1_valid)
    );

    sprite_priority_mux u_result (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .stage1_i        (stage1),
        .stage1_valid_i  (stage1_valid),
        .dot_rising_1_i  (dot_rising_1),
        .mode_i          (mode_i),
        .ec_i            (ec_i),
        .sprites_i       (sprites_i),
        .pixel_color_o   (pixel_color_o),
        .is_background_o (is_background_o)
    );

endmodule

`default_nettype wire

/* dv/pixel_sequencer_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_sequencer_tb;
    import vic_video_pkg::*;
    import vic_sprite_pkg::*;

    localparam int NUM_ROWS       = 15;
    localparam int RESET_CYCLES   = 5;
    localparam int SETTLE_CLOCKS  = 128;
    localparam int CHECK_CLOCKS   = 32;
    localparam int TIMEOUT_CLOCKS = NUM_ROWS * 160 + 100;
    localparam logic [15:0] LFSR_SEED = 16'd17888;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;
    // same scroll in every row, so the cell loads stay 8 dots apart
    localparam xpos_t ROW_XSCROLL = 3'd5;

    // one stimulus row and the color it must produce
    typedef struct packed {
        display_mode_e mode;
        pixel_byte_t   pixels;
        char_word_t    chr;
        bg_colors_t    bg;
        color_t        ec;
        logic          border;
        sprite_bus_t   sprites;
        xpos_t         xscroll;
        color_t        expected;
        logic          expected_bg;
    } row_t;

    logic          clk_dot4x;
    logic          rst;
    display_mode_e mode;
    pixel_byte_t   pixels_read;
    char_word_t    char_read;
    xpos_t         xscroll;
    bg_colors_t    bg;
    color_t        ec;
    logic          main_border;
    sprite_bus_t   sprites;
    color_t        pixel_color;
    logic          is_background;

    row_t        rows [NUM_ROWS];
    logic [15:0] lfsr_state;
    int          cycle_count = 0;

    pixel_sequencer u_dut (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .mode_i          (mode),
        .pixels_read_i   (pixels_read),
        .char_read_i     (char_read),
        .xscroll_i       (xscroll),
        .bg_i            (bg),
        .ec_i            (ec),
        .main_border_i   (main_border),
        .sprites_i       (sprites),
        .pixel_color_o   (pixel_color),
        .is_background_o (is_background)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #4 clk_dot4x = ~clk_dot4x;
    end

    always @(posedge clk_dot4x) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CLOCKS) begin
            $display("Timeout: the run did not finish within %0d clocks", TIMEOUT_CLOCKS);
            $display("Test failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic color_t next_random_color();
        color_t c;
        for (int i = 0; i < 4; i++) begin
            c[i]       = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        return c;
    endfunction

    // random colors everywhere, no sprite pixels, no border
    function automatic row_t new_row(input display_mode_e m, input pixel_byte_t p);
        row_t r;
        r        = '0;
        r.mode   = m;
        r.pixels = p;
        r.chr    = {next_random_color(), next_random_color(), next_random_color()};
        r.bg.b0c = next_random_color();
        r.bg.b1c = next_random_color();
        r.bg.b2c = next_random_color();
        r.bg.b3c = next_random_color();
        r.ec     = next_random_color();
        for (int n = 0; n < NUM_SPRITES; n++) begin
            r.sprites.col[n] = next_random_color();
        end
        r.sprites.mc0 = next_random_color();
        r.sprites.mc1 = next_random_color();
        r.xscroll     = ROW_XSCROLL;
        // all bits clear, or only the low bit of every multicolor pair set
        r.expected_bg = (p == 8'h00) || (p == 8'h55);
        return r;
    endfunction

    task automatic build_table();
        row_t r;
        r = new_row(MODE_STD_CHAR, 8'hFF);
        r.expected = r.chr[11:8];
        rows[0] = r;
        r = new_row(MODE_STD_CHAR, 8'h00);
        r.expected = r.bg.b0c;
        rows[1] = r;
        r = new_row(MODE_MC_CHAR, 8'h55);
        r.chr[11]  = 1'b1;
        r.expected = r.bg.b1c;
        rows[2] = r;
        r = new_row(MODE_MC_CHAR, 8'hAA);
        r.chr[11]  = 1'b1;
        r.expected = r.bg.b2c;
        rows[3] = r;
        r = new_row(MODE_MC_BITMAP, 8'h55);
        r.expected = r.chr[7:4];
        rows[4] = r;
        r = new_row(MODE_STD_BITMAP, 8'hFF);
        r.expected = r.chr[7:4];
        rows[5] = r;
        r = new_row(MODE_EXT_BG, 8'h00);
        r.chr[7:6] = 2'b11;
        r.expected = r.bg.b3c;
        rows[6] = r;
        r = new_row(MODE_INV_EXT_STD_BITMAP, 8'hFF);
        r.expected = COLOR_BLACK;
        rows[7] = r;
        // sprite in front of the blacked out graphics
        r = new_row(MODE_INV_EXT_STD_BITMAP, 8'hFF);
        r.sprites.cur_pixel[4] = 2'b10;
        r.expected = r.sprites.col[4];
        rows[8] = r;
        r = new_row(MODE_STD_CHAR, 8'hFF);
        r.sprites.cur_pixel[2] = 2'b10;
        r.expected = r.sprites.col[2];
        rows[9] = r;
        // behind foreground, graphics stay in front
        r = new_row(MODE_STD_CHAR, 8'hFF);
        r.sprites.cur_pixel[2] = 2'b10;
        r.sprites.pri[2]       = 1'b1;
        r.sprites.col[2]       = ~r.chr[11:8];
        r.expected = r.chr[11:8];
        rows[10] = r;
        r = new_row(MODE_STD_CHAR, 8'h00);
        r.sprites.cur_pixel[5] = 2'b11;
        r.sprites.mmc[5]       = 1'b1;
        r.sprites.pri[5]       = 1'b1;
        r.expected = r.sprites.mc1;
        rows[11] = r;
        r = new_row(MODE_STD_CHAR, 8'h00);
        r.sprites.cur_pixel[1] = 2'b10;
        r.sprites.cur_pixel[6] = 2'b10;
        r.sprites.col[6]       = ~r.sprites.col[1];
        r.expected = r.sprites.col[1];
        rows[12] = r;
        r = new_row(MODE_MC_BITMAP, 8'h55);
        r.sprites.cur_pixel[0] = 2'b10;
        r.border   = 1'b1;
        r.expected = r.ec;
        rows[13] = r;
        r = new_row(MODE_INV_EXT_MC_BITMAP, 8'h00);
        r.sprites.cur_pixel[3] = 2'b11;
        r.sprites.mmc[3]       = 1'b1;
        r.border   = 1'b1;
        r.expected = r.ec;
        rows[14] = r;
    endtask

    task automatic apply_row(input row_t r);
        mode        = r.mode;
        pixels_read = r.pixels;
        char_read   = r.chr;
        xscroll     = r.xscroll;
        bg          = r.bg;
        ec          = r.ec;
        main_border = r.border;
        sprites     = r.sprites;
    endtask

    task automatic check_color(input color_t actual, input color_t expected, input int row);
        if (actual !== expected) begin
            $display("Mismatch: pixel_color_o row %0d got 0x%h expected 0x%h",
                     row, actual, expected);
            $display("Test failed");
            $fatal(1, "pixel color check stopped the run");
        end
    endtask

    task automatic check_background(input logic actual, input logic expected, input int row);
        if (actual !== expected) begin
            $display("Mismatch: is_background_o row %0d got 0x%h expected 0x%h",
                     row, actual, expected);
            $display("Test failed");
            $fatal(1, "background flag check stopped the run");
        end
    endtask

    initial begin
        rst         = 1'b1;
        mode        = MODE_STD_CHAR;
        pixels_read = '0;
        char_read   = '0;
        xscroll     = '0;
        bg          = '0;
        ec          = '0;
        main_border = 1'b0;
        sprites     = '0;
        lfsr_state  = LFSR_SEED;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        rst = 1'b0;
        // each row spans 160 clocks, a whole number of phi cycles
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(rows[i]);
            repeat (SETTLE_CLOCKS) @(negedge clk_dot4x);
            for (int k = 0; k < CHECK_CLOCKS; k++) begin
                check_color(pixel_color, rows[i].expected, i);
                check_background(is_background, rows[i].expected_bg, i);
                @(negedge clk_dot4x);
            end
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
verilog/vic_video_pkg.sv
verilog/vic_sprite_pkg.sv
verilog/dot_timing.sv
verilog/gfx_shifter.sv
verilog/mode_color_resolver.sv
verilog/sprite_priority_mux.sv
verilog/pixel_sequencer.sv
dv/pixel_sequencer_tb.sv

/* run.sh */
#!/bin/sh
# build the pixel sequencer testbench with Verilator and run it
# the result is taken from the simulation log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module pixel_sequencer_tb -f tb.f -o sim_pixel_sequencer \
    > build.log 2>&1 || { cat build.log; echo "BUILD FAILED"; exit 1; }
./obj_dir/sim_pixel_sequencer > sim.log 2>&1
grep -q "Test completed successfully" sim.log && echo "PASS" || \
    { cat sim.log; echo "FAIL"; exit 1; }
